// ==== files.f ====
source/smc_lite_pkg.sv
source/smc_request_latch.sv
source/smc_strobe_timer.sv
source/smc_wr_enable_lite.sv
source/smc_read_capture.sv
source/smc_lite.sv
bench/smc_clock_gen.sv
bench/smc_sram_model.sv
bench/smc_lite_tb.sv

// ==== Bender.yml ====
package:
  name: smc_lite

sources:
  - files:
      - source/smc_lite_pkg.sv
      - source/smc_request_latch.sv
      - source/smc_strobe_timer.sv
      - source/smc_wr_enable_lite.sv
      - source/smc_read_capture.sv
      - source/smc_lite.sv
  - target: test
    files:
      - bench/smc_clock_gen.sv
      - bench/smc_sram_model.sv
      - bench/smc_lite_tb.sv

// ==== bench/smc_lite_tb.sv ====
/*
  directed testbench for smc_lite with a behavioral SRAM on the pins
  inputs change on the falling edge and outputs are sampled there too
  the shadow memory follows the byte-lane rule; partial writes only go
  to words that were first written in full
*/
`default_nettype none

module smc_lite_tb;

  // accesses over all tests, rounded up
  localparam int access_count = 60;
  localparam int watchdog_cycles = access_count * 10 + 200;
  // longest wait for one handshake
  localparam int wait_limit = 20;

  logic                                 hclk;
  logic                                 rst;
  logic                                 req_valid;
  logic                                 req_write;
  logic [smc_lite_pkg::addr_width-1:0]  req_addr;
  logic [smc_lite_pkg::data_width-1:0]  req_wdata;
  logic [smc_lite_pkg::lane_count-1:0]  req_be;
  logic                                 rsp_ready;
  wire                                  req_ready;
  wire                                  rsp_valid;
  wire  [smc_lite_pkg::data_width-1:0]  rsp_rdata;
  wire  [smc_lite_pkg::data_width-1:0]  smc_data_in;
  wire  [smc_lite_pkg::addr_width-1:0]  smc_addr;
  wire  [smc_lite_pkg::data_width-1:0]  smc_data_out;
  wire                                  smc_data_oe;
  wire                                  smc_n_cs;
  wire                                  smc_n_oe;
  wire  [smc_lite_pkg::lane_count-1:0]  smc_n_we;
  wire                                  smc_n_wr;

  // expected memory, keyed by word address
  logic [smc_lite_pkg::data_width-1:0] shadow [int];
  // addresses written in full, pool for random reads
  int written [$];
  logic [31:0] rng_state;
  int error_count;
  int tests_passed;
  int tests_failed;

  smc_clock_gen #(.period(40)) clock_gen (.clk(hclk));

  smc_lite smc_lite_inst (
    .hclk         (hclk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_be       (req_be),
    .req_ready    (req_ready),
    .rsp_valid    (rsp_valid),
    .rsp_rdata    (rsp_rdata),
    .rsp_ready    (rsp_ready),
    .smc_data_in  (smc_data_in),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_data_oe  (smc_data_oe),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr)
  );

  smc_sram_model sram_model (
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_data_oe  (smc_data_oe),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_we     (smc_n_we),
    .smc_data_in  (smc_data_in)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // only enabled bytes take the new data
  function automatic logic [smc_lite_pkg::data_width-1:0] merge_lanes(
    input logic [smc_lite_pkg::data_width-1:0] old_word,
    input logic [smc_lite_pkg::data_width-1:0] new_word,
    input logic [smc_lite_pkg::lane_count-1:0] be
  );
    logic [smc_lite_pkg::data_width-1:0] result;
    int i;
    result = old_word;
    for (i = 0; i < smc_lite_pkg::lane_count; i++)
      if (be[i])
        result[8*i +: 8] = new_word[8*i +: 8];
    return result;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, expected);
      error_count++;
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("at %0t: %s", $time, what);
      error_count++;
    end
  endtask

  task automatic close_test(input string name, input int start_errors);
    if (error_count == start_errors)
    begin
      tests_passed++;
      $display("%s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, error_count - start_errors);
    end
  endtask

  // returns on the falling edge after the accepting edge
  task automatic issue_request(input logic is_write,
                               input logic [smc_lite_pkg::addr_width-1:0] addr,
                               input logic [smc_lite_pkg::data_width-1:0] data,
                               input logic [smc_lite_pkg::lane_count-1:0] be);
    int waited;
    waited = 0;
    @(negedge hclk);
    req_valid = 1'b1;
    req_write = is_write;
    req_addr  = addr;
    req_wdata = data;
    req_be    = be;
    while (!req_ready && waited < wait_limit)
    begin
      @(negedge hclk);
      waited++;
    end
    confirm(req_ready, "request was never accepted");
    @(posedge hclk);
    @(negedge hclk);
    req_valid = 1'b0;
    if (is_write)
      shadow[addr] = merge_lanes(shadow.exists(addr) ? shadow[addr] : '0, data, be);
  endtask

  // latency counts falling edges from acceptance to rsp_valid
  task automatic read_word(input logic [smc_lite_pkg::addr_width-1:0] addr,
                           output logic [smc_lite_pkg::data_width-1:0] data,
                           output int latency);
    issue_request(1'b0, addr, '0, '0);
    latency = 0;
    while (!rsp_valid && latency < wait_limit)
    begin
      @(negedge hclk);
      latency++;
    end
    confirm(rsp_valid, "no read response arrived");
    data = rsp_rdata;
  endtask

  task automatic read_check(input logic [smc_lite_pkg::addr_width-1:0] addr);
    logic [smc_lite_pkg::data_width-1:0] data;
    int latency;
    read_word(addr, data, latency);
    compare_value("rsp_rdata", data, shadow[addr]);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic reset_state();
    int start_errors;
    start_errors = error_count;
    compare_value("req_ready", req_ready, 1'b1);
    compare_value("rsp_valid", rsp_valid, 1'b0);
    compare_value("smc_n_cs", smc_n_cs, 1'b1);
    compare_value("smc_n_oe", smc_n_oe, 1'b1);
    compare_value("smc_n_we", smc_n_we, 4'hf);
    compare_value("smc_n_wr", smc_n_wr, 1'b1);
    compare_value("smc_data_oe", smc_data_oe, 1'b0);
    close_test("reset state", start_errors);
  endtask

  task automatic word_round_trip();
    int start_errors;
    int latency;
    logic [smc_lite_pkg::data_width-1:0] data;
    start_errors = error_count;
    issue_request(1'b1, 'h10, 32'hcafe_f00d, 4'hf);
    latency = 0;
    while (!req_ready && latency < wait_limit)
    begin
      @(negedge hclk);
      latency++;
    end
    compare_value("req_ready latency after write", latency, 5);
    read_word('h10, data, latency);
    compare_value("rsp_valid latency", latency, 5);
    compare_value("rsp_rdata", data, 32'hcafe_f00d);
    close_test("word write then read", start_errors);
  endtask

  task automatic byte_lane_merge();
    int start_errors;
    int i;
    // single lanes, then pairs
    logic [19:0] lane_sets;
    start_errors = error_count;
    lane_sets = 20'b1010_1100_0011_0100_0001;
    issue_request(1'b1, 'h20, 32'h1122_3344, 4'hf);
    read_check('h20);
    for (i = 0; i < 5; i++)
    begin
      issue_request(1'b1, 'h20, 32'ha0b1_c2d3 + i * 32'h0101_0101, lane_sets[4*i +: 4]);
      read_check('h20);
    end
    close_test("byte-lane merge", start_errors);
  endtask

  task automatic strobe_shape();
    int start_errors;
    int cs_low;
    int wr_low;
    int lane_low [smc_lite_pkg::lane_count];
    int i;
    int c;
    logic cs_on;
    logic strobe_on;
    logic [smc_lite_pkg::lane_count-1:0] be;
    logic [smc_lite_pkg::lane_count-1:0] lanes_expect;
    start_errors = error_count;
    cs_low = 0;
    wr_low = 0;
    for (i = 0; i < smc_lite_pkg::lane_count; i++)
      lane_low[i] = 0;
    be = 4'b0101;
    // full word first so the untouched lanes are known
    issue_request(1'b1, 'h30, 32'h0f1e_2d3c, 4'hf);
    issue_request(1'b1, 'h30, 32'h5a5a_a5a5, be);
    // c counts cycles from acceptance, cs in 1 to 4, strobes in 2 and 3
    for (c = 0; c < 8; c++)
    begin
      cs_on     = (c >= 1) && (c <= 4);
      strobe_on = (c == 2) || (c == 3);
      if (!smc_n_cs)
        cs_low++;
      if (!smc_n_wr)
        wr_low++;
      for (i = 0; i < smc_lite_pkg::lane_count; i++)
        if (!smc_n_we[i])
          lane_low[i]++;
      lanes_expect = strobe_on ? ~be : '1;
      compare_value("smc_n_we", smc_n_we, lanes_expect);
      compare_value("smc_n_wr", smc_n_wr, !strobe_on);
      compare_value("smc_n_cs", smc_n_cs, !cs_on);
      compare_value("smc_n_oe", smc_n_oe, 1'b1);
      compare_value("smc_data_oe", smc_data_oe, cs_on);
      @(negedge hclk);
    end
    compare_value("smc_n_cs low cycles", cs_low, 4);
    compare_value("smc_n_wr low cycles", wr_low, 2);
    for (i = 0; i < smc_lite_pkg::lane_count; i++)
      compare_value("smc_n_we lane low cycles", lane_low[i], be[i] ? 2 : 0);
    read_check('h30);
    close_test("strobe shape", start_errors);
  endtask

  task automatic response_backpressure();
    int start_errors;
    int latency;
    logic [smc_lite_pkg::data_width-1:0] held;
    start_errors = error_count;
    // previous response drains on this edge
    @(negedge hclk);
    rsp_ready = 1'b0;
    read_word('h10, held, latency);
    compare_value("rsp_rdata", held, shadow['h10]);
    fork
      // a new request waits behind the pending response
      issue_request(1'b1, 'h40, 32'h0bad_beef, 4'hf);
      begin
        repeat (6)
        begin
          @(negedge hclk);
          compare_value("rsp_valid", rsp_valid, 1'b1);
          compare_value("rsp_rdata", rsp_rdata, held);
          compare_value("req_ready", req_ready, 1'b0);
          compare_value("smc_n_cs", smc_n_cs, 1'b1);
        end
        rsp_ready = 1'b1;
      end
    join
    compare_value("rsp_valid after handshake", rsp_valid, 1'b0);
    read_check('h40);
    close_test("response back-pressure", start_errors);
  endtask

  task automatic random_traffic();
    int start_errors;
    int i;
    logic [31:0] r;
    logic [smc_lite_pkg::addr_width-1:0] addr;
    logic [smc_lite_pkg::lane_count-1:0] be;
    start_errors = error_count;
    for (i = 0; i < 40; i++)
    begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      if (r[0] || written.size() == 0)
      begin
        // small window so reads hit merged words
        addr = 'h100 + r[5:1];
        be = r[9:6];
        if (!shadow.exists(addr))
        begin
          // first write to a word is a full one
          be = '1;
          written.push_back(addr);
        end
        rng_state = xorshift32(rng_state);
        issue_request(1'b1, addr, rng_state, be);
      end
      else
      begin
        addr = written[r[31:8] % written.size()];
        read_check(addr);
      end
    end
    close_test("random traffic", start_errors);
  endtask

  // --------------------------------------------------
  // run
  // --------------------------------------------------
  initial
  begin
    rst          = 1'b1;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    req_be       = '0;
    rsp_ready    = 1'b1;
    rng_state    = 32'h89b0_9ff6;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge hclk);
    @(negedge hclk);
    rst = 1'b0;
    reset_state();
    word_round_trip();
    byte_lane_merge();
    strobe_shape();
    response_backpressure();
    random_traffic();
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (watchdog_cycles) @(posedge hclk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/smc_sram_model.sv ====
/*
  behavioral asynchronous SRAM, one 32-bit word per address, byte lanes
  read data is combinational while cs and oe are low, otherwise zero
  a lane is written on the rising edge of its write enable, cs low
  preloaded with a pattern derived from the full address
*/
`default_nettype none

module smc_sram_model (
  input  wire  [smc_lite_pkg::addr_width-1:0]  smc_addr,
  input  wire  [smc_lite_pkg::data_width-1:0]  smc_data_out,
  input  wire                                  smc_data_oe,
  input  wire                                  smc_n_cs,
  input  wire                                  smc_n_oe,
  input  wire  [smc_lite_pkg::lane_count-1:0]  smc_n_we,
  output wire  [smc_lite_pkg::data_width-1:0]  smc_data_in
);

  logic [smc_lite_pkg::data_width-1:0] mem [0:(1 << smc_lite_pkg::addr_width) - 1];
  // previous lane enables, for edge detection
  logic [smc_lite_pkg::lane_count-1:0] we_last = '1;

  // odd multiplier keeps every word distinct
  initial
  begin
    int a;
    for (a = 0; a < (1 << smc_lite_pkg::addr_width); a++)
      mem[a] = a * 32'h9e37_79b9;
  end

  assign smc_data_in = (!smc_n_cs && !smc_n_oe) ? mem[smc_addr] : '0;

  // write on the trailing edge of each lane strobe
  always @(smc_n_we)
  begin
    int i;
    for (i = 0; i < smc_lite_pkg::lane_count; i++)
    begin
      if (smc_n_we[i] && !we_last[i] && !smc_n_cs && smc_data_oe)
        mem[smc_addr][8*i +: 8] = smc_data_out[8*i +: 8];
    end
    we_last = smc_n_we;
  end

endmodule

`default_nettype wire

// ==== bench/smc_clock_gen.sv ====
/*
  free-running testbench clock, starts low
  period should be even
*/
`default_nettype none

module smc_clock_gen #(
  parameter int period = 40
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== source/smc_lite.sv ====
/*
  lite static memory controller, single chip select, single word access
  one access on the pins at a time; response back-pressure stalls only
  new requests. timing comes from smc_lite_pkg
*/
`default_nettype none

module smc_lite (
  input  wire                                  hclk,
  input  wire                                  rst,
  // host request channel
  input  wire                                  req_valid,
  input  wire                                  req_write,
  input  wire  [smc_lite_pkg::addr_width-1:0]  req_addr,
  input  wire  [smc_lite_pkg::data_width-1:0]  req_wdata,
  input  wire  [smc_lite_pkg::lane_count-1:0]  req_be,
  output wire                                  req_ready,
  // host response channel
  output wire                                  rsp_valid,
  output wire  [smc_lite_pkg::data_width-1:0]  rsp_rdata,
  input  wire                                  rsp_ready,
  // memory pins
  input  wire  [smc_lite_pkg::data_width-1:0]  smc_data_in,
  output wire  [smc_lite_pkg::addr_width-1:0]  smc_addr,
  output wire  [smc_lite_pkg::data_width-1:0]  smc_data_out,
  output wire                                  smc_data_oe,
  output wire                                  smc_n_cs,
  output wire                                  smc_n_oe,
  output wire  [smc_lite_pkg::lane_count-1:0]  smc_n_we,
  output wire                                  smc_n_wr
);

  // --------------------------------------------------
  // internal wiring
  // --------------------------------------------------
  wire                                  start;
  wire                                  access_write;
  wire [smc_lite_pkg::lane_count-1:0]   n_r_we;
  wire smc_lite_pkg::phase_t            phase;
  wire                                  busy;
  wire                                  r_full;
  wire                                  n_r_wr;
  wire                                  rsp_pending;

  // request capture and flow control
  smc_request_latch smc_request_latch (
    .hclk         (hclk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_be       (req_be),
    .busy         (busy),
    .rsp_pending  (rsp_pending),
    .req_ready    (req_ready),
    .start        (start),
    .access_write (access_write),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .n_r_we       (n_r_we)
  );

  // phase sequencing
  smc_strobe_timer smc_strobe_timer (
    .hclk         (hclk),
    .rst          (rst),
    .start        (start),
    .access_write (access_write),
    .phase        (phase),
    .busy         (busy),
    .r_full       (r_full),
    .n_r_wr       (n_r_wr),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_data_oe  (smc_data_oe)
  );

  // write strobe pin stage
  smc_wr_enable_lite smc_wr_enable_lite (
    .hclk     (hclk),
    .rst      (rst),
    .r_full   (r_full),
    .n_r_we   (n_r_we),
    .n_r_wr   (n_r_wr),
    .smc_n_we (smc_n_we),
    .smc_n_wr (smc_n_wr)
  );

  // read data and response
  smc_read_capture smc_read_capture (
    .hclk        (hclk),
    .rst         (rst),
    .phase       (phase),
    .smc_n_oe    (smc_n_oe),
    .smc_data_in (smc_data_in),
    .rsp_ready   (rsp_ready),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .rsp_pending (rsp_pending)
  );

endmodule

`default_nettype wire

// ==== source/smc_read_capture.sv ====
/*
  read data capture and host response channel
  samples while oe is low in strobe, so the last strobe edge wins
  holds the word and rsp_valid until rsp_ready; writes never respond
*/
`default_nettype none

module smc_read_capture (
  input  wire                                  hclk,
  input  wire                                  rst,
  input  wire smc_lite_pkg::phase_t            phase,
  input  wire                                  smc_n_oe,
  input  wire  [smc_lite_pkg::data_width-1:0]  smc_data_in,
  input  wire                                  rsp_ready,
  output logic                                 rsp_valid,
  output logic [smc_lite_pkg::data_width-1:0]  rsp_rdata,
  output logic                                 rsp_pending
);

  logic sample;
  // set once the strobe has been sampled, until hold
  logic read_seen;

  // oe low only for reads, so no direction input needed
  assign sample = (phase == smc_lite_pkg::phase_strobe) && !smc_n_oe;

  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      read_seen <= 1'b0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      if (sample)
        read_seen <= 1'b1;
      else if (read_seen && (phase == smc_lite_pkg::phase_hold))
      begin
        // strobe done, present the word
        read_seen <= 1'b0;
        rsp_valid <= 1'b1;
      end
      if (rsp_valid && rsp_ready)
        rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge hclk)
  begin
    if (sample)
      rsp_rdata <= smc_data_in;
  end

  assign rsp_pending = read_seen || rsp_valid;

  // response is held steady under back-pressure
  a_rsp_hold: assert property (@(posedge hclk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

`default_nettype wire

// ==== source/smc_wr_enable_lite.sv ====
/*
  last stage before the write strobe pins
  strobes are forced high outside the full-cycle window, then registered
  so they leave the chip glitch-free; adds one cycle of latency
*/
`default_nettype none

module smc_wr_enable_lite (
  input  wire                                  hclk,
  input  wire                                  rst,
  input  wire                                  r_full,
  input  wire  [smc_lite_pkg::lane_count-1:0]  n_r_we,
  input  wire                                  n_r_wr,
  output logic [smc_lite_pkg::lane_count-1:0]  smc_n_we,
  output logic                                 smc_n_wr
);

  // --------------------------------------------------
  // gate with window, then register
  // --------------------------------------------------
  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      // all strobes inactive
      smc_n_we <= '1;
      smc_n_wr <= 1'b1;
    end
    else
    begin
      // lane low only inside the window and when enabled
      smc_n_we <= n_r_we | {smc_lite_pkg::lane_count{!r_full}};
      smc_n_wr <= n_r_wr | !r_full;
    end
  end

  // a lane strobe is never active without the common strobe
  a_we_needs_wr: assert property (@(posedge hclk) disable iff (rst)
    !(&smc_n_we) |-> !smc_n_wr);

endmodule

`default_nettype wire

// ==== source/smc_strobe_timer.sv ====
/*
  fixed external cycle sequencer: setup, strobe, hold
  cs, oe and data drive are registered from the next phase
  r_full and n_r_wr lead the pins by one cycle; the write-enable stage
  registers them so all strobes line up with chip select
*/
`default_nettype none

module smc_strobe_timer (
  input  wire                   hclk,
  input  wire                   rst,
  input  wire                   start,
  input  wire                   access_write,
  output smc_lite_pkg::phase_t  phase,
  output logic                  busy,
  output logic                  r_full,
  output logic                  n_r_wr,
  output logic                  smc_n_cs,
  output logic                  smc_n_oe,
  output logic                  smc_data_oe
);

  smc_lite_pkg::phase_t phase_q;
  smc_lite_pkg::phase_t phase_d;
  smc_lite_pkg::count_t count_q;
  smc_lite_pkg::count_t count_d;

  // --------------------------------------------------
  // next phase and down-counter
  // --------------------------------------------------
  always_comb
  begin
    phase_d = phase_q;
    count_d = count_q - 1'b1;
    case (phase_q)
      smc_lite_pkg::phase_idle:
      begin
        count_d = '0;
        if (start)
        begin
          phase_d = smc_lite_pkg::phase_setup;
          count_d = smc_lite_pkg::count_t'(smc_lite_pkg::setup_cycles - 1);
        end
      end
      smc_lite_pkg::phase_setup:
        if (count_q == '0)
        begin
          phase_d = smc_lite_pkg::phase_strobe;
          count_d = smc_lite_pkg::count_t'(smc_lite_pkg::strobe_cycles - 1);
        end
      smc_lite_pkg::phase_strobe:
        if (count_q == '0)
        begin
          phase_d = smc_lite_pkg::phase_hold;
          count_d = smc_lite_pkg::count_t'(smc_lite_pkg::hold_cycles - 1);
        end
      default:
        // hold, back to idle when done
        if (count_q == '0)
        begin
          phase_d = smc_lite_pkg::phase_idle;
          count_d = '0;
        end
    endcase
  end

  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      phase_q     <= smc_lite_pkg::phase_idle;
      count_q     <= '0;
      smc_n_cs    <= 1'b1;
      smc_n_oe    <= 1'b1;
      smc_data_oe <= 1'b0;
    end
    else
    begin
      phase_q     <= phase_d;
      count_q     <= count_d;
      // cs low across setup, strobe and hold
      smc_n_cs    <= (phase_d == smc_lite_pkg::phase_idle);
      // oe only in strobe of a read
      smc_n_oe    <= !((phase_d == smc_lite_pkg::phase_strobe) && !access_write);
      // drive the bus for the whole write cycle
      smc_data_oe <= (phase_d != smc_lite_pkg::phase_idle) && access_write;
    end
  end

  assign phase  = phase_q;
  assign busy   = (phase_q != smc_lite_pkg::phase_idle);
  // decided one cycle ahead of the strobe phase
  assign r_full = (phase_d == smc_lite_pkg::phase_strobe) && access_write;
  assign n_r_wr = !r_full;

  // read enable and write window never overlap on the bus
  a_oe_vs_full: assert property (@(posedge hclk) disable iff (rst) !(r_full && !smc_n_oe));

endmodule

`default_nettype wire

// ==== source/smc_request_latch.sv ====
/*
  host request front end, one access in flight at a time
  fields are captured on the accepting edge and held until the next accept
  req_ready is low while the timer runs or a read response is pending
*/
`default_nettype none

module smc_request_latch (
  input  wire                                    hclk,
  input  wire                                    rst,
  input  wire                                    req_valid,
  input  wire                                    req_write,
  input  wire  [smc_lite_pkg::addr_width-1:0]    req_addr,
  input  wire  [smc_lite_pkg::data_width-1:0]    req_wdata,
  input  wire  [smc_lite_pkg::lane_count-1:0]    req_be,
  input  wire                                    busy,
  input  wire                                    rsp_pending,
  output logic                                   req_ready,
  output logic                                   start,
  output logic                                   access_write,
  output logic [smc_lite_pkg::addr_width-1:0]    smc_addr,
  output logic [smc_lite_pkg::data_width-1:0]    smc_data_out,
  output logic [smc_lite_pkg::lane_count-1:0]    n_r_we
);

  logic accept;

  // start covers the gap before the timer leaves idle
  assign req_ready = !busy && !rsp_pending && !start;
  assign accept    = req_valid && req_ready;

  // --------------------------------------------------
  // control state
  // --------------------------------------------------
  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      start        <= 1'b0;
      access_write <= 1'b0;
    end
    else
    begin
      // one-cycle pulse per accepted request
      start <= accept;
      if (accept)
        access_write <= req_write;
    end
  end

  // --------------------------------------------------
  // payload, held for the whole external cycle
  // --------------------------------------------------
  always_ff @(posedge hclk)
  begin
    if (accept)
    begin
      smc_addr     <= req_addr;
      smc_data_out <= req_wdata;
      // lane enables kept active low for the pin stage
      n_r_we       <= ~req_be;
    end
  end

  // the timer must be idle whenever a new access is launched
  a_start_idle: assert property (@(posedge hclk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// ==== source/smc_lite_pkg.sv ====
/*
  shared constants and types for the lite static memory controller
  timing is fixed here; there are no wait-state registers
  phase lengths must each be at least 1 and fit in count_t
*/
`default_nettype none

package smc_lite_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  // word address into the external device
  localparam int addr_width = 16;
  // one 32-bit word per access, no width conversion
  localparam int data_width = 32;
  // one active-low write enable per byte
  localparam int lane_count = 4;

  // --------------------------------------------------
  // external cycle timing, in hclk cycles
  // --------------------------------------------------
  // chip select low to strobe low
  localparam int setup_cycles = 1;
  // strobe low time
  localparam int strobe_cycles = 2;
  // strobe high to chip select high
  localparam int hold_cycles = 1;

  // phase down-counter, wide enough for the longest phase
  localparam int count_width = 2;
  typedef logic [count_width-1:0] count_t;

  // --------------------------------------------------
  // access phase encoding
  // --------------------------------------------------
  typedef enum logic [1:0] {
    phase_idle   = 2'b00,
    phase_setup  = 2'b01,
    phase_strobe = 2'b10,
    phase_hold   = 2'b11
  } phase_t;

endpackage

`default_nettype wire
